/* source/mem_model_pkg.sv */
`default_nettype none

package mem_model_pkg;

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 64;
   localparam int STRB_W     = 8;
   localparam int ID_W       = 8;
   localparam int LEN_W      = 4;
   localparam int MEM_WORDS  = 256;
   localparam int FIFO_DEPTH = 16;
   localparam int LATENCY    = 30;
   localparam int CYC_W      = 16;

   // word index sits at byte address bits 10:3
   localparam int IDX_W   = $clog2(MEM_WORDS);
   localparam int IDX_LSB = $clog2(STRB_W);

   // queue pointers, depth is a power of two
   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // shared by the aw and ar channels
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } addr_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } wdata_t;

   // one queued beat, due is the cycle stamp it waits for
   typedef struct packed {
      logic              is_read;
      logic [ID_W-1:0]   id;
      logic [IDX_W-1:0]  index;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
      logic [CYC_W-1:0]  due;
   } beat_req_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      logic              last;
   } rresp_t;

   typedef struct packed {
      logic [ID_W-1:0] id;
   } bresp_t;

endpackage

`default_nettype wire

/* source/beat_fifo.sv */
`default_nettype none

module beat_fifo (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     push,
   input  mem_model_pkg::beat_req_t push_beat,
   input  logic                     pop,
   output mem_model_pkg::beat_req_t head,
   output logic                     not_empty,
   output logic                     has_space
);
   import mem_model_pkg::*;

   beat_req_t        entries [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap on their own width
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_beat;
      end
   end

   assign head      = entries[rd_ptr];
   assign not_empty = (count != '0);
   assign has_space = (count != (PTR_W + 1)'(FIFO_DEPTH));

   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
      push |-> has_space)
      else $error("beat_fifo push while full");

   a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
      pop |-> not_empty)
      else $error("beat_fifo pop while empty");

endmodule

`default_nettype wire

/* source/cycle_timer.sv */
`default_nettype none

module cycle_timer (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic [mem_model_pkg::CYC_W-1:0] head_stamp,
   output logic [mem_model_pkg::CYC_W-1:0] now,
   output logic                            head_due
);
   import mem_model_pkg::*;

   logic [CYC_W-1:0] since;

   // free running count from reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         now <= '0;
      end else begin
         now <= now + 1'b1;
      end
   end

   // sign bit stays set while the stamp is still ahead
   assign since = now - head_stamp;

   // due only strictly past the stamp so a beat waits LATENCY+1 cycles
   assign head_due = !since[CYC_W-1] && (since != '0);

endmodule

`default_nettype wire

/* source/ingress_fsm.sv */
`default_nettype none

module ingress_fsm (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            aw_valid,
   input  mem_model_pkg::addr_req_t        aw,
   output logic                            aw_ready,
   input  logic                            w_valid,
   input  mem_model_pkg::wdata_t           w,
   output logic                            w_ready,
   input  logic                            ar_valid,
   input  mem_model_pkg::addr_req_t        ar,
   output logic                            ar_ready,
   input  logic [mem_model_pkg::CYC_W-1:0] now,
   input  logic                            has_space,
   output logic                            push,
   output mem_model_pkg::beat_req_t        push_beat
);
   import mem_model_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ
   } state_t;

   state_t           state;
   logic             ports_open;
   logic [ID_W-1:0]  cur_id;
   logic [IDX_W-1:0] next_idx;
   logic [LEN_W-1:0] beats_left;
   logic             aw_fire;
   logic             ar_fire;
   logic             w_fire;
   logic             rd_push;

   // address ports stay shut until the first cycle out of reset
   assign aw_ready = ports_open && (state == IDLE);
   // aw wins when both arrive together
   assign ar_ready = ports_open && (state == IDLE) && !aw_valid;
   assign w_ready  = (state == WRITE) && has_space;

   assign aw_fire = aw_valid && aw_ready;
   assign ar_fire = ar_valid && ar_ready;
   assign w_fire  = w_valid && w_ready;
   assign rd_push = (state == READ) && has_space;
   assign push    = w_fire || rd_push;

   always_comb begin
      push_beat.is_read = (state == READ);
      push_beat.id      = cur_id;
      push_beat.index   = next_idx;
      push_beat.data    = (state == WRITE) ? w.data : '0;
      push_beat.strb    = (state == WRITE) ? w.strb : '0;
      push_beat.last    = (state == WRITE) ? w.last : (beats_left == '0);
      push_beat.due     = now + CYC_W'(LATENCY);
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state      <= IDLE;
         ports_open <= 1'b0;
         beats_left <= '0;
      end else begin
         ports_open <= 1'b1;
         case (state)
            IDLE: begin
               if (aw_fire) begin
                  state <= WRITE;
               end else if (ar_fire) begin
                  state      <= READ;
                  beats_left <= ar.len;
               end
            end
            WRITE: begin
               if (w_fire && w.last) begin
                  state <= IDLE;
               end
            end
            READ: begin
               if (rd_push) begin
                  beats_left <= beats_left - 1'b1;
                  if (beats_left == '0) begin
                     state <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // burst context
   always_ff @(posedge clk) begin
      if (aw_fire) begin
         cur_id   <= aw.id;
         next_idx <= aw.addr[IDX_LSB +: IDX_W];
      end else if (ar_fire) begin
         cur_id   <= ar.id;
         next_idx <= ar.addr[IDX_LSB +: IDX_W];
      end else if (push) begin
         next_idx <= next_idx + 1'b1;
      end
   end

   a_no_idle_push: assert property (@(posedge clk) disable iff (!rstn)
      push |-> (state != IDLE))
      else $error("ingress_fsm push in IDLE");

endmodule

`default_nettype wire

/* source/mem_array.sv */
`default_nettype none

module mem_array (
   input  logic                             clk,
   input  logic                             en,
   input  logic                             we,
   input  logic [mem_model_pkg::IDX_W-1:0]  index,
   input  logic [mem_model_pkg::DATA_W-1:0] wdata,
   input  logic [mem_model_pkg::STRB_W-1:0] strb,
   output logic [mem_model_pkg::DATA_W-1:0] rdata
);
   import mem_model_pkg::*;

   logic [DATA_W-1:0] words [MEM_WORDS];

   // byte lanes written only where the strobe is set
   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
               words[index][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

   // read data held until the next enabled read
   always_ff @(posedge clk) begin
      if (en && !we) begin
         rdata <= words[index];
      end
   end

endmodule

`default_nettype wire

/* source/resp_engine.sv */
`default_nettype none

module resp_engine (
   input  logic                             clk,
   input  logic                             rstn,
   input  mem_model_pkg::beat_req_t         head,
   input  logic                             not_empty,
   input  logic                             head_due,
   output logic                             pop,
   output logic                             ram_en,
   output logic                             ram_we,
   output logic [mem_model_pkg::IDX_W-1:0]  ram_index,
   output logic [mem_model_pkg::DATA_W-1:0] ram_wdata,
   output logic [mem_model_pkg::STRB_W-1:0] ram_strb,
   input  logic [mem_model_pkg::DATA_W-1:0] ram_rdata,
   output logic                             r_valid,
   output mem_model_pkg::rresp_t            r,
   input  logic                             r_ready,
   output logic                             b_valid,
   output mem_model_pkg::bresp_t            b,
   input  logic                             b_ready
);
   import mem_model_pkg::*;

   logic [ID_W-1:0] r_id_q;
   logic            r_last_q;
   logic [ID_W-1:0] b_id_q;
   logic            rd_pop;
   logic            wr_pop;

   // one response in flight at most, queue frozen meanwhile
   assign pop    = not_empty && head_due && !r_valid && !b_valid;
   assign rd_pop = pop && head.is_read;
   assign wr_pop = pop && !head.is_read;

   assign ram_en    = pop;
   assign ram_we    = wr_pop;
   assign ram_index = head.index;
   assign ram_wdata = head.data;
   assign ram_strb  = head.strb;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         r_valid <= 1'b0;
         b_valid <= 1'b0;
      end else begin
         if (rd_pop) begin
            r_valid <= 1'b1;
         end else if (r_ready) begin
            r_valid <= 1'b0;
         end
         // only the final write beat answers
         if (wr_pop && head.last) begin
            b_valid <= 1'b1;
         end else if (b_ready) begin
            b_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_pop) begin
         r_id_q   <= head.id;
         r_last_q <= head.last;
      end
      if (wr_pop && head.last) begin
         b_id_q <= head.id;
      end
   end

   // RAM output stays put since nothing is popped while r is pending
   always_comb begin
      r.id   = r_id_q;
      r.data = ram_rdata;
      r.last = r_last_q;
      b.id   = b_id_q;
   end

   a_r_stable: assert property (@(posedge clk) disable iff (!rstn)
      (r_valid && !r_ready) |=> (r_valid && $stable(r)))
      else $error("r payload changed while stalled");

   a_b_stable: assert property (@(posedge clk) disable iff (!rstn)
      (b_valid && !b_ready) |=> (b_valid && $stable(b)))
      else $error("b payload changed while stalled");

   a_one_resp: assert property (@(posedge clk) disable iff (!rstn)
      !(r_valid && b_valid))
      else $error("r and b valid together");

endmodule

`default_nettype wire

/* source/mem_model_top.sv */
`default_nettype none

module mem_model_top (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      aw_valid,
   input  mem_model_pkg::addr_req_t  aw,
   output logic                      aw_ready,
   input  logic                      w_valid,
   input  mem_model_pkg::wdata_t     w,
   output logic                      w_ready,
   input  logic                      ar_valid,
   input  mem_model_pkg::addr_req_t  ar,
   output logic                      ar_ready,
   output logic                      r_valid,
   output mem_model_pkg::rresp_t     r,
   input  logic                      r_ready,
   output logic                      b_valid,
   output mem_model_pkg::bresp_t     b,
   input  logic                      b_ready
);
   import mem_model_pkg::*;

   logic              push;
   beat_req_t         push_beat;
   logic              pop;
   beat_req_t         head;
   logic              not_empty;
   logic              has_space;
   logic [CYC_W-1:0]  now;
   logic              head_due;
   logic              ram_en;
   logic              ram_we;
   logic [IDX_W-1:0]  ram_index;
   logic [DATA_W-1:0] ram_wdata;
   logic [STRB_W-1:0] ram_strb;
   logic [DATA_W-1:0] ram_rdata;

   ingress_fsm ingress_fsm_i (
      .clk       (clk),
      .rstn      (rstn),
      .aw_valid  (aw_valid),
      .aw        (aw),
      .aw_ready  (aw_ready),
      .w_valid   (w_valid),
      .w         (w),
      .w_ready   (w_ready),
      .ar_valid  (ar_valid),
      .ar        (ar),
      .ar_ready  (ar_ready),
      .now       (now),
      .has_space (has_space),
      .push      (push),
      .push_beat (push_beat)
   );

   beat_fifo beat_fifo_i (
      .clk       (clk),
      .rstn      (rstn),
      .push      (push),
      .push_beat (push_beat),
      .pop       (pop),
      .head      (head),
      .not_empty (not_empty),
      .has_space (has_space)
   );

   // head stamp compared against the running count
   cycle_timer cycle_timer_i (
      .clk        (clk),
      .rstn       (rstn),
      .head_stamp (head.due),
      .now        (now),
      .head_due   (head_due)
   );

   mem_array mem_array_i (
      .clk   (clk),
      .en    (ram_en),
      .we    (ram_we),
      .index (ram_index),
      .wdata (ram_wdata),
      .strb  (ram_strb),
      .rdata (ram_rdata)
   );

   resp_engine resp_engine_i (
      .clk       (clk),
      .rstn      (rstn),
      .head      (head),
      .not_empty (not_empty),
      .head_due  (head_due),
      .pop       (pop),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_index (ram_index),
      .ram_wdata (ram_wdata),
      .ram_strb  (ram_strb),
      .ram_rdata (ram_rdata),
      .r_valid   (r_valid),
      .r         (r),
      .r_ready   (r_ready),
      .b_valid   (b_valid),
      .b         (b),
      .b_ready   (b_ready)
   );

endmodule

`default_nettype wire

/* dv/mem_model_tb.sv */
`default_nettype none

module mem_model_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import mem_model_pkg::*;

   localparam int CLK_PERIOD  = 8;
   localparam int NUM_TESTS   = 4;
   localparam int MAX_BEATS   = 16;
   localparam int TIMEOUT_CYC = NUM_TESTS * MAX_BEATS * (LATENCY + 40);

   // stamp holds the cycle of the request that completed the response
   typedef struct packed {
      logic              is_read;
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      logic              last;
      logic [31:0]       stamp;
   } exp_resp_t;

   logic      clk;
   logic      rstn;
   logic      aw_valid;
   addr_req_t aw;
   logic      aw_ready;
   logic      w_valid;
   wdata_t    w;
   logic      w_ready;
   logic      ar_valid;
   addr_req_t ar;
   logic      ar_ready;
   logic      r_valid;
   rresp_t    r;
   logic      r_ready;
   logic      b_valid;
   bresp_t    b;
   logic      b_ready;

   logic [DATA_W-1:0] shadow [MEM_WORDS];
   exp_resp_t         exp_q [$];
   exp_resp_t         exp_head;
   logic              exp_any;
   logic [31:0]       cycle;
   logic              rstn_q;
   logic [ID_W-1:0]   wr_id;
   logic [IDX_W-1:0]  wr_idx;
   logic [31:0]       stim_seed;
   logic              stall_mode;
   int                errors;
   int                tests_done;
   int                r_beats;
   int                b_resps;
   int                sent_r_beats;
   int                sent_w_bursts;
   int                w_stalls;

   mem_model_top mem_model_top_i (
      .clk      (clk),
      .rstn     (rstn),
      .aw_valid (aw_valid),
      .aw       (aw),
      .aw_ready (aw_ready),
      .w_valid  (w_valid),
      .w        (w),
      .w_ready  (w_ready),
      .ar_valid (ar_valid),
      .ar       (ar),
      .ar_ready (ar_ready),
      .r_valid  (r_valid),
      .r        (r),
      .r_ready  (r_ready),
      .b_valid  (b_valid),
      .b        (b),
      .b_ready  (b_ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // halves swapped since the low LCG bits repeat quickly
   function automatic logic [31:0] next_rand();
      stim_seed = lcg_step(stim_seed);
      return {stim_seed[15:0], stim_seed[31:16]};
   endfunction

   // random bits outside the word index must be ignored by the DUT
   function automatic logic [ADDR_W-1:0] addr_for(input logic [IDX_W-1:0] idx);
      logic [31:0]       s;
      logic [ADDR_W-1:0] a;
      s = next_rand();
      a = s[ADDR_W-1:0];
      a[IDX_LSB +: IDX_W] = idx;
      return a;
   endfunction

   task automatic note_mismatch(input string msg);
      errors++;
      $display("Mismatch at %0d ns: %s", $time, msg);
   endtask

   task automatic note_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   always @(posedge clk) begin
      cycle  <= cycle + 1;
      rstn_q <= rstn;
   end

   // shadow memory and expected responses in acceptance order
   always @(posedge clk) begin
      exp_resp_t        e;
      logic [IDX_W-1:0] idx;
      if (rstn) begin
         if (aw_valid && aw_ready) begin
            wr_id  = aw.id;
            wr_idx = aw.addr[IDX_LSB +: IDX_W];
         end
         if (w_valid && w_ready) begin
            for (int i = 0; i < STRB_W; i++) begin
               if (w.strb[i]) begin
                  shadow[wr_idx][8*i +: 8] = w.data[8*i +: 8];
               end
            end
            if (w.last) begin
               e = '{is_read: 1'b0, id: wr_id, data: '0, last: 1'b1, stamp: cycle};
               exp_q.push_back(e);
            end
            wr_idx = wr_idx + 1'b1;
         end
         if (ar_valid && ar_ready) begin
            idx = ar.addr[IDX_LSB +: IDX_W];
            for (int i = 0; i <= int'(ar.len); i++) begin
               e = '{is_read: 1'b1, id: ar.id, data: shadow[idx],
                     last: (i == int'(ar.len)), stamp: cycle};
               exp_q.push_back(e);
               idx = idx + 1'b1;
            end
         end
         if ((r_valid && r_ready) || (b_valid && b_ready)) begin
            if (exp_q.size() > 0) begin
               void'(exp_q.pop_front());
            end
            if (r_valid && r_ready) begin
               r_beats++;
            end else begin
               b_resps++;
            end
         end
         exp_any = (exp_q.size() > 0);
         if (exp_any) begin
            exp_head = exp_q[0];
         end
      end
   end

   a_reset_quiet: assert property (@(posedge clk)
      (cycle != 0 && (!rstn || !rstn_q)) |->
         !(aw_ready || w_ready || ar_ready || r_valid || b_valid))
      else note_mismatch("ready or valid high during or right after reset");

   a_r_order: assert property (@(posedge clk) disable iff (!rstn)
      (r_valid && r_ready) |-> (exp_any && exp_head.is_read && r.id == exp_head.id))
      else note_mismatch("read response out of order or with a wrong id");

   a_r_data: assert property (@(posedge clk) disable iff (!rstn)
      (r_valid && r_ready) |-> (r.data == exp_head.data && r.last == exp_head.last))
      else note_mismatch("read data or last differs from the shadow memory");

   a_b_order: assert property (@(posedge clk) disable iff (!rstn)
      (b_valid && b_ready) |-> (exp_any && !exp_head.is_read && b.id == exp_head.id))
      else note_mismatch("write response out of order or with a wrong id");

   a_min_latency: assert property (@(posedge clk) disable iff (!rstn)
      ((r_valid && r_ready) || (b_valid && b_ready)) |->
         (cycle - exp_head.stamp >= 32'(LATENCY + 2)))
      else note_mismatch("response arrived before the minimum latency");

   a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
      (r_valid && !r_ready) |=> (r_valid && $stable(r)))
      else note_mismatch("read response changed while stalled");

   a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
      (b_valid && !b_ready) |=> (b_valid && $stable(b)))
      else note_mismatch("write response changed while stalled");

   // ready sampled at the falling edge before the transfer edge
   task automatic wait_ready(input int ch);
      logic ready;
      ready = 1'b0;
      while (!ready) begin
         @(negedge clk);
         case (ch)
            0:       ready = aw_ready;
            1:       ready = w_ready;
            default: ready = ar_ready;
         endcase
         if (ch == 1 && !ready) begin
            w_stalls++;
         end
         @(posedge clk);
         #1;
      end
   endtask

   // strb_sel of zero picks random strobes
   task automatic write_burst(input logic [ID_W-1:0] id, input logic [IDX_W-1:0] idx,
                              input logic [LEN_W-1:0] len, input logic [STRB_W-1:0] strb_sel);
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] s;
      aw_valid = 1'b1;
      aw       = '{id: id, addr: addr_for(idx), len: len};
      wait_ready(0);
      aw_valid = 1'b0;
      for (int i = 0; i <= int'(len); i++) begin
         hi      = next_rand();
         lo      = next_rand();
         s       = next_rand();
         w_valid = 1'b1;
         w.data  = {hi, lo};
         w.strb  = (strb_sel != '0) ? strb_sel : s[STRB_W-1:0];
         w.last  = (i == int'(len));
         wait_ready(1);
      end
      w_valid = 1'b0;
      sent_w_bursts++;
   endtask

   task automatic read_burst(input logic [ID_W-1:0] id, input logic [IDX_W-1:0] idx,
                             input logic [LEN_W-1:0] len);
      ar_valid = 1'b1;
      ar       = '{id: id, addr: addr_for(idx), len: len};
      wait_ready(2);
      ar_valid = 1'b0;
      sent_r_beats += int'(len) + 1;
   endtask

   // stays inside words 0 to 62 that the preload wrote
   task automatic random_burst();
      logic [31:0] s;
      s = next_rand();
      if (s[0]) begin
         write_burst(s[15:8], IDX_W'(s[21:16] % 48), s[27:24], '0);
      end else begin
         read_burst(s[15:8], IDX_W'(s[21:16] % 48), s[27:24]);
      end
   endtask

   task automatic end_test(input string name);
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      tests_done++;
      $display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
   endtask

   // random ready stalls on their own LCG stream
   initial begin
      logic [31:0] s;
      r_ready = 1'b1;
      b_ready = 1'b1;
      s = lcg_step(32'd55);
      forever begin
         @(posedge clk);
         #1;
         s = lcg_step(s);
         r_ready = stall_mode ? s[30] : 1'b1;
         b_ready = stall_mode ? s[29] : 1'b1;
      end
   end

   initial begin
      int stalls_before;
      aw_valid      = 1'b0;
      aw            = '0;
      w_valid       = 1'b0;
      w             = '0;
      ar_valid      = 1'b0;
      ar            = '0;
      rstn          = 1'b0;
      rstn_q        = 1'b0;
      cycle         = '0;
      stall_mode    = 1'b0;
      stim_seed     = 32'd55;
      exp_any       = 1'b0;
      exp_head      = '0;
      wr_id         = '0;
      wr_idx        = '0;
      errors        = 0;
      tests_done    = 0;
      r_beats       = 0;
      b_resps       = 0;
      sent_r_beats  = 0;
      sent_w_bursts = 0;
      w_stalls      = 0;
      repeat (5) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(posedge clk);
      #1;
      end_test("reset");

      write_burst(8'h11, 8'd200, 4'd0, 8'hff);
      write_burst(8'h12, 8'd200, 4'd0, 8'h5a);
      read_burst(8'h13, 8'd200, 4'd0);
      end_test("strobe merge");

      for (int i = 0; i < 4; i++) begin
         write_burst(ID_W'(i), IDX_W'(16 * i), 4'd15, 8'hff);
      end
      for (int i = 0; i < 12; i++) begin
         random_burst();
      end
      end_test("random bursts");

      // two back to back long writes fill the queue
      stalls_before = w_stalls;
      stall_mode    = 1'b1;
      write_burst(8'hb0, 8'd0, 4'd15, '0);
      write_burst(8'hb1, 8'd16, 4'd15, '0);
      read_burst(8'hb2, 8'd0, 4'd15);
      for (int i = 0; i < 6; i++) begin
         random_burst();
      end
      assert (w_stalls != stalls_before)
         else note_failure("write channel never stalled while the queue was full");
      end_test("back-pressure");
      stall_mode = 1'b0;

      assert (r_beats == sent_r_beats && b_resps == sent_w_bursts)
         else note_failure("response counts do not match the requests sent");
      $display("tests %0d, read beats %0d of %0d, write responses %0d of %0d, errors %0d",
               tests_done, r_beats, sent_r_beats, b_resps, sent_w_bursts, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("run timed out after %0d cycles with responses outstanding", TIMEOUT_CYC);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
source/mem_model_pkg.sv
source/beat_fifo.sv
source/cycle_timer.sv
source/ingress_fsm.sv
source/mem_array.sv
source/resp_engine.sv
source/mem_model_top.sv
dv/mem_model_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the memory model testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mem_model_tb -f project.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vmem_model_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
   exit 0
fi
exit 1
